// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = rename_tb
FLIST = all.f
MDIR  = obj_dir
LOG   = sim.log
PASS  = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(MDIR)
	./$(MDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(MDIR) $(LOG)

// File: all.f
+incdir+src
src/rename_pkg.sv
src/rename_ctrl.sv
src/ckpt_counter.sv
src/map_table.sv
src/free_list.sv
src/rename_unit.sv
bench/clock_gen.sv
bench/rename_tb.sv

// File: bench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
    end

    always #4 clk = ~clk;  // 8 ns period

endmodule

// File: bench/rename_tb.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_tb;
    import rename_pkg::*;

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam int RAND_ITEMS = 150;
    localparam int ISSUED     = 3 + 9 + (`PHYS_REGS - `ARCH_REGS + 1) + 11 + 1 + RAND_ITEMS;
    localparam int LIMIT      = 20 * ISSUED + 200;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    rename_req_t in_req;
    logic        out_valid;
    logic        out_ready;
    rename_rsp_t out_rsp;
    branch_res_t br_res;
    commit_t     commit;

    logic [`PHYS_W-1:0] m_map [`ARCH_REGS];
    logic [`PHYS_W-1:0] m_page_map [`CKPT_PAGES][`ARCH_REGS];
    logic [`PHYS_W-1:0] m_page_head [`CKPT_PAGES];
    logic [`PHYS_W-1:0] m_fq [`PHYS_REGS];  // Model free queue
    logic [`PHYS_W-1:0] m_head = '0;
    logic [`PHYS_W-1:0] m_tail = `PHYS_W'(`PHYS_REGS - `ARCH_REGS);
    int                 m_free = `PHYS_REGS - `ARCH_REGS;
    int                 ck_tail = 0;
    rename_rsp_t        exp_q [$];
    rename_rsp_t        exp_rsp;
    rename_rsp_t        last_rsp;
    logic [`PHYS_W-1:0] freed_q [$];  // Old tags, handed back later as commits
    logic [6:0]         ops [9] = '{OP_BRANCH, OP_STORE, OP_JAL, OP_JALR, OP_LUI,
                                    OP_AUIPC, OP_LOAD, OP_IMM, OP_REG};
    int                 errors = 0;
    int                 checks = 0;
    int                 tests = 0;
    int                 clean = 0;
    int                 mark = 0;
    int                 cycles = 0;
    int                 p;
    int                 base;
    bit                 rand_ready = 1'b0;
    logic [`PHYS_W-1:0] tag;
    logic [`PHYS_W-1:0] next_tag;
    logic [6:0]         op;

    clock_gen u_clk (.clk(clk), .reset(reset));

    rename_unit DUT (.*);

    function automatic rename_rsp_t model_rename(input rename_req_t req);
        rename_rsp_t rsp;
        logic        no_src1;
        logic        no_src2;
        logic        has_rd;
        no_src1 = req.opcode inside {OP_LUI, OP_AUIPC, OP_JAL};
        no_src2 = no_src1 || (req.opcode inside {OP_JALR, OP_LOAD, OP_IMM});
        has_rd  = !(req.opcode inside {OP_BRANCH, OP_STORE});
        rsp.opcode    = req.opcode;
        rsp.src1_tag  = no_src1 ? `NO_TAG : m_map[req.rs1];
        rsp.src2_tag  = no_src2 ? `NO_TAG : m_map[req.rs2];
        rsp.dst_tag   = has_rd ? m_fq[m_head] : `NO_TAG;
        rsp.old_tag   = has_rd ? m_map[req.rd] : `NO_TAG;
        rsp.has_ckpt  = (req.opcode == OP_BRANCH);
        rsp.ckpt_page = rsp.has_ckpt ? `CKPT_W'(ck_tail) : '0;
        if (has_rd) begin
            m_map[req.rd] = rsp.dst_tag;
            m_head = m_head + 1'b1;
            m_free--;
            freed_q.push_back(rsp.old_tag);
        end
        if (rsp.has_ckpt) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                m_page_map[ck_tail][i] = m_map[i];
            end
            m_page_head[ck_tail] = m_head;
            ck_tail = (ck_tail + 1) % `CKPT_PAGES;
        end
        return rsp;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic issue(input logic [6:0] opc, input int rs1, input int rs2, input int rd);
        in_req   = '{opcode: opc, rs1: `ARCH_W'(rs1), rs2: `ARCH_W'(rs2), rd: `ARCH_W'(rd)};
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        exp_q.push_back(model_rename(in_req));  // Transfers on the coming edge
        @(posedge clk);
        #1 in_valid = 1'b0;
    endtask

    task automatic give_back(input logic [`PHYS_W-1:0] ret_tag);
        commit = '{valid: 1'b1, tag: ret_tag};
        m_fq[m_tail] = ret_tag;
        m_tail = m_tail + 1'b1;
        m_free++;
        @(posedge clk);
        #1 commit = '0;
    endtask

    task automatic resolve(input logic mis, input int page);
        br_res = '{valid: 1'b1, mispredict: mis, page: `CKPT_W'(page)};
        if (mis) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                m_map[i] = m_page_map[page][i];
            end
            m_head  = m_page_head[page];
            m_free  = int'(`PHYS_W'(m_tail - m_head));  // Commits since the save stay
            ck_tail = page;
        end
        @(posedge clk);
        #1 br_res = '0;
    endtask

    task automatic expect_stall(input logic [6:0] opc);
        in_req.opcode = opc;
        in_valid      = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check("in_ready", 64'(in_ready), 64'(0));
        end
        @(posedge clk);
        #1 in_valid = 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic end_test(input string name);
        drain();
        tests++;
        if (errors == mark) begin
            clean++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    // Responses are compared in order, one per transfer
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("DUT sent a response at %0t that no request asked for", $time);
            end else begin
                exp_rsp = exp_q.pop_front();
                check("out_rsp", 64'(out_rsp), 64'(exp_rsp));
            end
            last_rsp = out_rsp;
        end
    end

    always @(posedge clk) begin
        #1 out_ready = rand_ready ? ($urandom % 4 != 0) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h12b8));
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        br_res    = '0;
        commit    = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            m_map[i] = `PHYS_W'(i);
        end
        for (int i = 0; i < `PHYS_REGS - `ARCH_REGS; i++) begin
            m_fq[i] = `PHYS_W'(`ARCH_REGS + i);
        end
        @(negedge clk);
        while (reset) begin
            check("in_ready", 64'(in_ready), 64'(0));
            check("out_valid", 64'(out_valid), 64'(0));
            @(negedge clk);
        end
        @(posedge clk);
        #1;

        for (int i = 0; i < 3; i++) begin
            issue(OP_REG, i + 1, i + 4, i + 10);
        end
        drain();
        check("src1_tag", 64'(last_rsp.src1_tag), 64'(3));
        check("src2_tag", 64'(last_rsp.src2_tag), 64'(6));
        check("dst_tag", 64'(last_rsp.dst_tag), 64'(34));
        end_test("reset mapping");

        foreach (ops[k]) begin
            issue(ops[k], $urandom % 32, $urandom % 32, $urandom % 32);
        end
        resolve(1'b0, 0);
        end_test("opcode rules");

        while (m_free > 0) begin
            issue(OP_REG, $urandom % 32, $urandom % 32, $urandom % 32);
        end
        expect_stall(OP_REG);
        tag = freed_q.pop_front();
        give_back(tag);
        issue(OP_REG, 1, 2, 3);
        drain();
        check("dst_tag", 64'(last_rsp.dst_tag), 64'(tag));
        repeat (64) give_back(freed_q.pop_front());
        end_test("free list exhaustion");

        issue(OP_REG, 5, 6, 7);
        p = ck_tail;
        issue(OP_BRANCH, 7, 5, 0);
        next_tag = m_fq[m_head];
        base = freed_q.size();
        issue(OP_REG, 7, 7, 5);  // Wrong path from here
        issue(OP_BRANCH, 5, 1, 0);
        issue(OP_LOAD, 5, 0, 7);
        issue(OP_BRANCH, 7, 1, 0);
        drain();
        resolve(1'b1, p);
        while (freed_q.size() > base) begin
            void'(freed_q.pop_back());
        end
        issue(OP_REG, 5, 7, 9);
        drain();
        check("dst_tag", 64'(last_rsp.dst_tag), 64'(next_tag));
        repeat (`CKPT_PAGES) issue(OP_BRANCH, 1, 2, 0);
        end_test("mispredict recovery");

        expect_stall(OP_BRANCH);
        resolve(1'b0, 0);
        issue(OP_BRANCH, 3, 4, 0);
        repeat (`CKPT_PAGES) resolve(1'b0, 0);
        end_test("checkpoint pages full");

        rand_ready = 1'b1;
        repeat (RAND_ITEMS) begin
            if (m_free < 8) begin
                repeat (4) give_back(freed_q.pop_front());
            end
            op = ops[$urandom % 9];
            issue(op, $urandom % 32, $urandom % 32, $urandom % 32);
            if (op == OP_BRANCH) begin
                resolve(1'b0, 0);
            end
        end
        end_test("random back-pressure");
        rand_ready = 1'b0;

        $display("%0d tests, %0d clean, %0d checks, %0d errors", tests, clean, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src/ckpt_counter.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module ckpt_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               alloc,
    input  logic               release_oldest,  // A branch resolved
    input  logic               flush_from,      // ...and it mispredicted
    input  logic [`CKPT_W-1:0] flush_page,
    output logic [`CKPT_W-1:0] alloc_page,
    output logic               full
);

    localparam logic [`CKPT_W:0] ALL_PAGES = `CKPT_PAGES;

    logic [`CKPT_W-1:0] head_q;   // Oldest page in use
    logic [`CKPT_W-1:0] tail_q;   // Next page to hand out
    logic [`CKPT_W:0]   count_q;
    logic [`CKPT_W-1:0] flush_span;
    logic               do_flush;
    logic               do_release;

    assign do_flush   = release_oldest && flush_from;
    assign do_release = release_oldest && !flush_from && (count_q != '0);
    assign flush_span = flush_page - head_q;  // Pages older than the flushed one
    assign alloc_page = tail_q;
    assign full       = (count_q == ALL_PAGES);

    always_ff @(posedge clk) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (do_flush) begin
            tail_q  <= flush_page;
            count_q <= {1'b0, flush_span};
        end else begin
            if (alloc) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_release) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc, do_release})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: src/free_list.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module free_list (
    input  logic                clk,
    input  logic                reset,
    input  logic                take,
    input  rename_pkg::commit_t commit,
    input  logic                do_save,
    input  logic                do_restore,
    input  logic [`CKPT_W-1:0]  page,
    output logic [`PHYS_W-1:0]  head_tag,
    output logic                empty
);

    localparam int FREE_INIT = `PHYS_REGS - `ARCH_REGS;

    logic [`PHYS_W-1:0] queue_q [`PHYS_REGS];
    logic [`PHYS_W-1:0] saved_head_q [`CKPT_PAGES];
    logic [`PHYS_W-1:0] head_q;
    logic [`PHYS_W-1:0] tail_q;
    logic [`PHYS_W:0]   count_q;
    logic [`PHYS_W-1:0] head_next;
    logic [`PHYS_W-1:0] tail_next;
    logic [`PHYS_W-1:0] restore_span;

    assign head_next    = take ? head_q + 1'b1 : head_q;
    assign tail_next    = commit.valid ? tail_q + 1'b1 : tail_q;
    assign restore_span = tail_next - saved_head_q[page];  // Keeps tags freed since the save
    assign head_tag     = queue_q[head_q];
    assign empty        = (count_q == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FREE_INIT; i++) begin
                queue_q[i] <= `PHYS_W'(`ARCH_REGS + i);  // Tags 32 and up
            end
        end else if (commit.valid) begin
            queue_q[tail_q] <= commit.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= `PHYS_W'(FREE_INIT);
            count_q <= (`PHYS_W + 1)'(FREE_INIT);
        end else begin
            tail_q <= tail_next;
            if (do_restore) begin
                head_q  <= saved_head_q[page];
                count_q <= {1'b0, restore_span};
            end else begin
                head_q <= head_next;
                case ({commit.valid, take})
                    2'b10:   count_q <= count_q + 1'b1;
                    2'b01:   count_q <= count_q - 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_save) begin
            saved_head_q[page] <= head_next;
        end
    end

endmodule

// File: src/map_table.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module map_table (
    input  logic               clk,
    input  logic               reset,
    input  logic [`ARCH_W-1:0] rs1,
    input  logic [`ARCH_W-1:0] rs2,
    input  logic [`ARCH_W-1:0] rd,
    input  logic [`PHYS_W-1:0] new_tag,
    input  logic               do_rename,
    input  logic               do_save,
    input  logic               do_restore,
    input  logic [`CKPT_W-1:0] page,
    output logic [`PHYS_W-1:0] src1_tag,
    output logic [`PHYS_W-1:0] src2_tag,
    output logic [`PHYS_W-1:0] old_tag
);

    // Speculative map
    logic [`PHYS_W-1:0] map_q    [`ARCH_REGS];
    logic [`PHYS_W-1:0] map_next [`ARCH_REGS];

    // One full copy per checkpoint page
    logic [`PHYS_W-1:0] page_q [`CKPT_PAGES][`ARCH_REGS];

    // Reads see the map before this cycle's write
    assign src1_tag = map_q[rs1];
    assign src2_tag = map_q[rs2];
    assign old_tag  = map_q[rd];

    always_comb begin
        for (int i = 0; i < `ARCH_REGS; i++) begin
            map_next[i] = map_q[i];
        end
        if (do_rename) begin
            map_next[rd] = new_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= `PHYS_W'(i);  // Identity mapping
            end
        end else if (do_restore) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= page_q[page][i];
            end
        end else begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= map_next[i];
            end
        end
    end

    // Snapshot includes the mapping written this cycle
    always_ff @(posedge clk) begin
        if (do_save) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                page_q[page][i] <= map_next[i];
            end
        end
    end

endmodule

// File: src/rename_ctrl.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  rename_pkg::rename_req_t in_req,
    output logic                   out_valid,
    input  logic                   out_ready,
    output rename_pkg::rename_rsp_t out_rsp,
    input  rename_pkg::branch_res_t br_res,
    input  logic                   fl_empty,
    input  logic                   ck_full,
    input  logic [`PHYS_W-1:0]     src1_tag,
    input  logic [`PHYS_W-1:0]     src2_tag,
    input  logic [`PHYS_W-1:0]     old_tag,
    input  logic [`PHYS_W-1:0]     new_tag,
    input  logic [`CKPT_W-1:0]     ck_page,
    output logic                   do_rename,
    output logic                   do_save,
    output logic                   do_restore
);
    import rename_pkg::*;

    ctrl_state_t state_q;
    rename_rsp_t rsp_d;
    logic        mask_src1;
    logic        mask_src2;
    logic        needs_rd;
    logic        is_branch;
    logic        accept;
    logic        mispredict;

    always_comb begin
        mask_src1 = 1'b0;
        mask_src2 = 1'b0;
        needs_rd  = 1'b1;
        is_branch = 1'b0;
        case (in_req.opcode)
            OP_LUI, OP_AUIPC, OP_JAL: begin
                mask_src1 = 1'b1;
                mask_src2 = 1'b1;
            end
            OP_JALR, OP_LOAD, OP_IMM: mask_src2 = 1'b1;
            OP_BRANCH: begin
                needs_rd  = 1'b0;
                is_branch = 1'b1;
            end
            OP_STORE: needs_rd = 1'b0;
            default: ;
        endcase
    end

    assign mispredict = br_res.valid && br_res.mispredict;

    assign in_ready = (state_q == RUN) && (!out_valid || out_ready) &&
                      !(needs_rd && fl_empty) && !(is_branch && ck_full);
    assign accept     = in_valid && in_ready;
    assign do_rename  = accept && needs_rd;
    assign do_save    = accept && is_branch;
    assign do_restore = (state_q == RECOVER);  // Page is already the flushed one

    always_comb begin
        rsp_d.opcode    = in_req.opcode;
        rsp_d.src1_tag  = mask_src1 ? `NO_TAG : src1_tag;
        rsp_d.src2_tag  = mask_src2 ? `NO_TAG : src2_tag;
        rsp_d.dst_tag   = needs_rd ? new_tag : `NO_TAG;
        rsp_d.old_tag   = needs_rd ? old_tag : `NO_TAG;
        rsp_d.has_ckpt  = is_branch;
        rsp_d.ckpt_page = is_branch ? ck_page : '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= HOLD;  // Quiet until reset is gone
            out_valid <= 1'b0;
        end else begin
            state_q <= mispredict ? RECOVER : RUN;
            if (mispredict) begin
                out_valid <= 1'b0;  // Drop wrong-path result
            end else if (accept) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_rsp <= rsp_d;
        end
    end

endmodule

// File: src/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Logical register file
`define ARCH_REGS 32
`define ARCH_W 5

// Physical register file
`define PHYS_W 7
`define PHYS_REGS (1 << `PHYS_W)

// Branch checkpoints
`define CKPT_PAGES 4
`define CKPT_W 2

// Tag meaning "no register"
`define NO_TAG {`PHYS_W{1'b1}}

`endif

// File: src/rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

    typedef struct packed {
        logic [6:0]         opcode;
        logic [`ARCH_W-1:0] rs1;
        logic [`ARCH_W-1:0] rs2;
        logic [`ARCH_W-1:0] rd;
    } rename_req_t;

    typedef struct packed {
        logic [6:0]         opcode;
        logic [`PHYS_W-1:0] src1_tag;
        logic [`PHYS_W-1:0] src2_tag;
        logic [`PHYS_W-1:0] dst_tag;
        logic [`PHYS_W-1:0] old_tag;   // Released at commit by the core
        logic               has_ckpt;
        logic [`CKPT_W-1:0] ckpt_page;
    } rename_rsp_t;

    typedef struct packed {
        logic               valid;
        logic               mispredict;
        logic [`CKPT_W-1:0] page;
    } branch_res_t;

    typedef struct packed {
        logic               valid;
        logic [`PHYS_W-1:0] tag;
    } commit_t;

    typedef enum logic [1:0] {
        RUN,
        HOLD,
        RECOVER
    } ctrl_state_t;

    // RV32I major opcodes
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;

endpackage

// File: src/rename_unit.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  rename_pkg::rename_req_t in_req,
    output logic                    out_valid,
    input  logic                    out_ready,
    output rename_pkg::rename_rsp_t out_rsp,
    input  rename_pkg::branch_res_t br_res,
    input  rename_pkg::commit_t     commit
);

    logic [`PHYS_W-1:0] src1_tag;
    logic [`PHYS_W-1:0] src2_tag;
    logic [`PHYS_W-1:0] old_tag;
    logic [`PHYS_W-1:0] new_tag;
    logic [`CKPT_W-1:0] ck_page;
    logic               fl_empty;
    logic               ck_full;
    logic               do_rename;
    logic               do_save;
    logic               do_restore;

    rename_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_rsp    (out_rsp),
        .br_res     (br_res),
        .fl_empty   (fl_empty),
        .ck_full    (ck_full),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .old_tag    (old_tag),
        .new_tag    (new_tag),
        .ck_page    (ck_page),
        .do_rename  (do_rename),
        .do_save    (do_save),
        .do_restore (do_restore)
    );

    ckpt_counter u_ckpt (
        .clk            (clk),
        .reset          (reset),
        .alloc          (do_save),
        .release_oldest (br_res.valid),
        .flush_from     (br_res.mispredict),
        .flush_page     (br_res.page),
        .alloc_page     (ck_page),
        .full           (ck_full)
    );

    map_table u_map (
        .clk        (clk),
        .reset      (reset),
        .rs1        (in_req.rs1),
        .rs2        (in_req.rs2),
        .rd         (in_req.rd),
        .new_tag    (new_tag),
        .do_rename  (do_rename),
        .do_save    (do_save),
        .do_restore (do_restore),
        .page       (ck_page),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .old_tag    (old_tag)
    );

    free_list u_free (
        .clk        (clk),
        .reset      (reset),
        .take       (do_rename),
        .commit     (commit),
        .do_save    (do_save),
        .do_restore (do_restore),
        .page       (ck_page),
        .head_tag   (new_tag),
        .empty      (fl_empty)
    );

endmodule
